// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_video -o tb_video
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_video > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== sim.f ====
src/video_pkg.sv
src/video_timing.sv
src/scroll_layer.sv
src/color_mixer.sv
src/video_top.sv
sim/tb_video.sv

// ==== sim/tb_video.sv ====
`timescale 1ns/10ps

module tb_video;
    import video_pkg::*;

    localparam int FRAME_PXL    = H_TOTAL * V_TOTAL;
    localparam int FRAME_CLKS   = 2 * FRAME_PXL;
    localparam int LOAD_CLKS    = NUM_LAYERS * 1024 + 256 + 2 * NUM_LAYERS;
    // Three tests of up to three frames each plus two content loads and one spare frame
    localparam int TIMEOUT_CLKS = 10 * FRAME_CLKS + 2 * LOAD_CLKS;

    logic      clk;
    logic      rst;
    logic      pxl_cen;
    cpu_addr_t cpu_addr;
    cpu_data_t cpu_dout;
    logic      cpu_we;
    logic      map_cs;
    logic      scr_cs;
    logic      pal_cs;
    logic      hs;
    logic      vs;
    logic      lhbl;
    logic      lvbl;
    logic      line_intn;
    chan_t     red;
    chan_t     green;
    chan_t     blue;

    // Reference model of everything the CPU has written
    logic [7:0]  map_m [NUM_LAYERS][1024];
    logic [7:0]  hscr_m [NUM_LAYERS];
    logic [7:0]  vscr_m [NUM_LAYERS];
    logic [14:0] pal_m [256];

    logic [31:0] rng_state;
    int          cycle_count;

    video_top dut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( cpu_we    ),
        .map_cs    ( map_cs    ),
        .scr_cs    ( scr_cs    ),
        .pal_cs    ( pal_cs    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .line_intn ( line_intn ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pixel enable on every second clock
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            pxl_cen = ~pxl_cen;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CLKS) begin
            $display("Timeout after %0d clock cycles, the tests did not finish", cycle_count);
            $display("Something failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Returns after the next pixel enable, once the outputs have settled
    task automatic next_pixel();
        do begin
            @(posedge clk);
        end while (pxl_cen !== 1'b1);
        @(negedge clk);
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic bus_write(input logic m, input logic s, input logic p,
                             input cpu_addr_t a, input cpu_data_t d);
        map_cs   = m;
        scr_cs   = s;
        pal_cs   = p;
        cpu_addr = a;
        cpu_dout = d;
        cpu_we   = 1'b1;
        @(posedge clk);
        #2;
    endtask

    task automatic bus_idle();
        cpu_we = 1'b0;
        map_cs = 1'b0;
        scr_cs = 1'b0;
        pal_cs = 1'b0;
    endtask

    // Mode 1 makes layer 0 mostly transparent and some of layer 1 as well
    task automatic fill_maps(input int mode);
        logic [31:0] r;
        logic [7:0]  v;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            for (int i = 0; i < 1024; i++) begin
                r = rand_next();
                v = r[23:16];
                if (mode == 1 && l == 0 && r[9:8] != 2'b00) begin
                    v[3:0] = 4'd0;
                end
                if (mode == 1 && l == 1 && r[11:10] == 2'b00) begin
                    v[3:0] = 4'd0;
                end
                map_m[l][i] = v;
                bus_write(1'b1, 1'b0, 1'b0, cpu_addr_t'(l * 1024 + i), {r[31:24], v});
            end
        end
    endtask

    task automatic fill_palette();
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            r = rand_next();
            pal_m[i] = r[30:16];
            bus_write(1'b0, 1'b0, 1'b1, cpu_addr_t'(i), {r[31], r[30:16]});
        end
    endtask

    task automatic set_scroll(input int l, input logic [7:0] h, input logic [7:0] v);
        hscr_m[l] = h;
        vscr_m[l] = v;
        bus_write(1'b0, 1'b1, 1'b0, cpu_addr_t'(l * 2), {8'hA5, h});
        bus_write(1'b0, 1'b1, 1'b0, cpu_addr_t'(l * 2 + 1), {8'h5A, v});
    endtask

    // Scroll, tile lookup, then first opaque layer in index order
    function automatic logic [14:0] model_rgb(input int line, input int col);
        int         hpos;
        int         vpos;
        logic [7:0] p;
        logic [7:0] idx;
        logic       found;
        idx   = 8'h00;
        found = 1'b0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            hpos = (col + int'(hscr_m[l])) % 256;
            vpos = (line + int'(vscr_m[l])) % 256;
            p = map_m[l][(vpos / 8) * 32 + hpos / 8];
            if (!found && p[3:0] != 4'd0) begin
                idx   = p;
                found = 1'b1;
            end
        end
        return pal_m[idx];
    endfunction

    task automatic check_idle(input string name);
        check_value({name, " hs"}, 32'(0), 32'(hs));
        check_value({name, " vs"}, 32'(0), 32'(vs));
        check_value({name, " lhbl"}, 32'(0), 32'(lhbl));
        check_value({name, " lvbl"}, 32'(0), 32'(lvbl));
        check_value({name, " rgb"}, 32'(0), 32'({red, green, blue}));
        check_value({name, " line_intn"}, 32'(1), 32'(line_intn));
    endtask

    // One full frame starting where active video ends
    // Pixel positions come from the blanking edges
    task automatic check_frame(input string name);
        int   line;
        int   col;
        int   frames;
        int   hs_rises;
        int   vs_rises;
        int   int_lows;
        int   low_len;
        logic prev_lhbl;
        logic prev_lvbl;
        logic prev_hs;
        logic prev_vs;
        logic prev_int;
        line     = 0;
        col      = 0;
        frames   = 0;
        hs_rises = 0;
        vs_rises = 0;
        int_lows = 0;
        low_len  = 0;
        while (lvbl !== 1'b1) next_pixel();
        while (lvbl !== 1'b0) next_pixel();
        prev_lhbl = lhbl;
        prev_lvbl = lvbl;
        prev_hs   = hs;
        prev_vs   = vs;
        prev_int  = line_intn;
        for (int n = 0; n < FRAME_PXL; n++) begin
            next_pixel();
            if (lvbl && !prev_lvbl) begin
                frames++;
                line = 0;
                col  = 0;
            end
            if (lvbl && lhbl) begin
                check_value($sformatf("%s pixel x%0d y%0d", name, col, line),
                            32'(model_rgb(line, col)), 32'({red, green, blue}));
                col++;
            end else begin
                check_value({name, " blanked rgb"}, 32'(0), 32'({red, green, blue}));
            end
            if (lvbl && prev_lhbl && !lhbl) begin
                check_value($sformatf("%s pixels on line %0d", name, line),
                            32'(H_ACTIVE), 32'(col));
                line++;
                col = 0;
            end
            if (!lvbl && prev_lvbl) begin
                check_value({name, " active lines"}, 32'(V_ACTIVE), 32'(line));
            end
            if (hs && !prev_hs) hs_rises++;
            if (vs && !prev_vs) vs_rises++;
            if (!line_intn) low_len++;
            if (line_intn && !prev_int) begin
                check_value({name, " line_intn low length"}, 32'(H_TOTAL), 32'(low_len));
                int_lows++;
                low_len = 0;
            end
            prev_lhbl = lhbl;
            prev_lvbl = lvbl;
            prev_hs   = hs;
            prev_vs   = vs;
            prev_int  = line_intn;
        end
        check_value({name, " frame starts"}, 32'(1), 32'(frames));
        check_value({name, " hs pulses"}, 32'(V_TOTAL), 32'(hs_rises));
        check_value({name, " vs pulses"}, 32'(1), 32'(vs_rises));
        check_value({name, " line interrupts"}, 32'(V_ACTIVE / LINE_INT_STEP), 32'(int_lows));
    endtask

    initial begin
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_we      = 1'b0;
        map_cs      = 1'b0;
        scr_cs      = 1'b0;
        pal_cs      = 1'b0;
        rng_state   = 32'h6914_d803;
        cycle_count = 0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            hscr_m[l] = 8'h00;
            vscr_m[l] = 8'h00;
        end

        repeat (8) begin
            @(posedge clk);
            #2;
            check_idle("reset hold");
        end
        rst = 1'b0;
        // Blanking pipeline keeps outputs quiet for the first enables
        repeat (3) begin
            next_pixel();
            check_idle("after reset");
        end

        @(posedge clk);
        #2;
        fill_palette();
        fill_maps(0);
        bus_idle();
        repeat (FRAME_PXL) next_pixel();
        check_frame("zero scroll");

        @(posedge clk);
        #2;
        set_scroll(0, 8'(rand_next() >> 24), 8'(rand_next() >> 24));
        // Layer 1 close to 256 so both axes wrap on screen
        set_scroll(1, 8'hF0 + 8'(rand_next() >> 28), 8'hF0 + 8'(rand_next() >> 28));
        bus_idle();
        repeat (FRAME_PXL) next_pixel();
        check_frame("scroll");

        @(posedge clk);
        #2;
        fill_maps(1);
        bus_idle();
        repeat (FRAME_PXL) next_pixel();
        check_frame("priority");

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== src/color_mixer.sv ====
`timescale 1ns/10ps

module color_mixer (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          pxl_cen,
    input  video_pkg::pxl_t [video_pkg::NUM_LAYERS-1:0]   layer_pxl,
    input  logic                                          pre_lhbl,
    input  logic                                          pre_lvbl,
    input  video_pkg::cpu_addr_t                          cpu_addr,
    input  video_pkg::cpu_data_t                          cpu_dout,
    input  logic                                          cpu_we,
    input  logic                                          pal_cs,
    output logic                                          lhbl,
    output logic                                          lvbl,
    output video_pkg::chan_t                              red,
    output video_pkg::chan_t                              green,
    output video_pkg::chan_t                              blue
);
    import video_pkg::*;

    rgb_t pal_ram [0:255];
    rgb_t pal_q;
    pxl_t pal_idx;
    logic pal_we;
    logic active;

    // Blanking travels alongside the layer and mixer stages
    logic [LAYER_DLY+MIX_DLY-1:0] lhbl_sr;
    logic [LAYER_DLY+MIX_DLY-1:0] lvbl_sr;

    assign pal_we = cpu_we && pal_cs;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[cpu_addr[7:0]] <= cpu_dout[14:0];
        end
    end

    // Lowest layer index with a visible colour wins, else backdrop 0
    always_comb begin
        pal_idx = '0;
        for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
            if (layer_pxl[i][3:0] != 4'd0) begin
                pal_idx = layer_pxl[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q <= pal_ram[pal_idx];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[LAYER_DLY+MIX_DLY-2:0], pre_lhbl};
            lvbl_sr <= {lvbl_sr[LAYER_DLY+MIX_DLY-2:0], pre_lvbl};
        end
    end

    // One tap early, since the RGB register adds the last stage
    assign active = lhbl_sr[LAYER_DLY+MIX_DLY-2] && lvbl_sr[LAYER_DLY+MIX_DLY-2];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            red   <= active ? pal_q[14:10] : '0;
            green <= active ? pal_q[9:5]   : '0;
            blue  <= active ? pal_q[4:0]   : '0;
        end
    end

    assign lhbl = lhbl_sr[LAYER_DLY+MIX_DLY-1];
    assign lvbl = lvbl_sr[LAYER_DLY+MIX_DLY-1];

endmodule

// ==== src/scroll_layer.sv ====
`timescale 1ns/10ps

module scroll_layer #(
    parameter int layer_id = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::pos_t      hdump,
    input  video_pkg::pos_t      vdump,
    input  video_pkg::cpu_addr_t cpu_addr,
    input  video_pkg::cpu_data_t cpu_dout,
    input  logic                 cpu_we,
    input  logic                 map_cs,
    input  logic                 scr_cs,
    output video_pkg::pxl_t      pxl
);
    import video_pkg::*;

    pxl_t      map_ram [0:2**$bits(map_addr_t)-1];
    pxl_t      map_q;
    scroll_t   hscroll;
    scroll_t   vscroll;
    scroll_t   hsum;
    scroll_t   vsum;
    map_addr_t map_addr;
    logic      map_we;
    logic      scr_we;

    // Layer field of the address picks this instance
    assign map_we = cpu_we && map_cs && (cpu_addr[11:10] == 2'(layer_id));
    assign scr_we = cpu_we && scr_cs && (cpu_addr[1] == 1'(layer_id));

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_ram[cpu_addr[9:0]] <= cpu_dout[7:0];
        end
    end

    // Bit 0 picks vertical over horizontal
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (scr_we) begin
            if (cpu_addr[0]) begin
                vscroll <= cpu_dout[7:0];
            end else begin
                hscroll <= cpu_dout[7:0];
            end
        end
    end

    // Scrolled position wraps at 256 on both axes
    assign hsum = hdump[7:0] + hscroll;
    assign vsum = vdump[7:0] + vscroll;

    // 8x8 tiles, 32 tiles per map row
    assign map_addr = {vsum[7:3], hsum[7:3]};

    // Map read, then output register
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            map_q <= map_ram[map_addr];
            pxl   <= map_q;
        end
    end

endmodule

// ==== src/video_pkg.sv ====
package video_pkg;

    // Screen geometry, counted in pixel enables and lines
    localparam int H_TOTAL       = 64;
    localparam int H_ACTIVE      = 48;
    localparam int HS_START      = 52;
    localparam int HS_LEN        = 4;

    localparam int V_TOTAL       = 40;
    localparam int V_ACTIVE      = 32;
    localparam int VS_START      = 35;
    localparam int VS_LEN        = 2;

    // Interrupt every 16 active lines
    localparam int LINE_INT_STEP = 16;

    // Layer count and pipeline depths, in pixel enables
    localparam int NUM_LAYERS    = 2;
    localparam int LAYER_DLY     = 2;
    localparam int MIX_DLY       = 2;

    // Raster position
    typedef logic [8:0]  pos_t;

    // CPU write port
    typedef logic [11:0] cpu_addr_t;
    typedef logic [15:0] cpu_data_t;

    // Layer data
    typedef logic [7:0]  scroll_t;
    typedef logic [9:0]  map_addr_t;
    // Upper nibble is the palette bank, lower nibble the colour (0 = transparent)
    typedef logic [7:0]  pxl_t;

    // Palette entry as {red, green, blue}
    typedef logic [14:0] rgb_t;
    typedef logic [4:0]  chan_t;

endpackage

// ==== src/video_timing.sv ====
`timescale 1ns/10ps

module video_timing (
    input  logic            clk,
    input  logic            rst,
    input  logic            pxl_cen,
    output video_pkg::pos_t hdump,
    output video_pkg::pos_t vdump,
    output logic            pre_lhbl,
    output logic            pre_lvbl,
    output logic            hs,
    output logic            vs,
    output logic            line_intn
);
    import video_pkg::*;

    logic h_wrap;
    pos_t v_next;

    assign h_wrap = (hdump == pos_t'(H_TOTAL - 1));

    // Line number that takes over at the end of the current line
    assign v_next = (vdump == pos_t'(V_TOTAL - 1)) ? '0 : vdump + 1'b1;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            hdump <= h_wrap ? '0 : hdump + 1'b1;
            if (h_wrap) begin
                vdump <= v_next;
            end
        end
    end

    // Blanking ahead of the layer and mixer pipeline
    assign pre_lhbl = (hdump < H_ACTIVE);
    assign pre_lvbl = (vdump < V_ACTIVE);

    assign hs = (hdump >= HS_START) && (hdump < HS_START + HS_LEN);
    assign vs = (vdump >= VS_START) && (vdump < VS_START + VS_LEN);

    // Loaded together with vdump so the low pulse covers exactly one line
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            line_intn <= 1'b1;
        end else if (pxl_cen && h_wrap) begin
            line_intn <= !((v_next % LINE_INT_STEP) == 0 && v_next < V_ACTIVE);
        end
    end

endmodule

// ==== src/video_top.sv ====
`timescale 1ns/10ps

module video_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::cpu_addr_t cpu_addr,
    input  video_pkg::cpu_data_t cpu_dout,
    input  logic                 cpu_we,
    input  logic                 map_cs,
    input  logic                 scr_cs,
    input  logic                 pal_cs,
    output logic                 hs,
    output logic                 vs,
    output logic                 lhbl,
    output logic                 lvbl,
    output logic                 line_intn,
    output video_pkg::chan_t     red,
    output video_pkg::chan_t     green,
    output video_pkg::chan_t     blue
);
    import video_pkg::*;

    pos_t                   hdump;
    pos_t                   vdump;
    logic                   pre_lhbl;
    logic                   pre_lvbl;
    pxl_t [NUM_LAYERS-1:0]  layer_pxl;

    video_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .pre_lhbl  ( pre_lhbl  ),
        .pre_lvbl  ( pre_lvbl  ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .line_intn ( line_intn )
    );

    // Identical layers, each decodes its own layer field
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        scroll_layer #(.layer_id(i)) u_layer (
            .clk      ( clk          ),
            .rst      ( rst          ),
            .pxl_cen  ( pxl_cen      ),
            .hdump    ( hdump        ),
            .vdump    ( vdump        ),
            .cpu_addr ( cpu_addr     ),
            .cpu_dout ( cpu_dout     ),
            .cpu_we   ( cpu_we       ),
            .map_cs   ( map_cs       ),
            .scr_cs   ( scr_cs       ),
            .pxl      ( layer_pxl[i] )
        );
    end

    color_mixer u_mixer (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .layer_pxl ( layer_pxl ),
        .pre_lhbl  ( pre_lhbl  ),
        .pre_lvbl  ( pre_lvbl  ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( cpu_we    ),
        .pal_cs    ( pal_cs    ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

endmodule
